//--- src/pairer_pkg.sv
`default_nettype none

package pairer_pkg;

  typedef logic [15:0] sample_t;
  typedef logic [7:0]  marker_t;

  typedef struct packed {
    marker_t marker;  // upper byte
    sample_t sample;
  } frame_t;

  localparam int FIFO_DEPTH_BITS        = 4;
  localparam int FIFO_ALMOSTFULL_LEVEL  = 2 ** FIFO_DEPTH_BITS - 4;
  localparam int FIFO_ALMOSTEMPTY_LEVEL = 2;

  localparam logic [3:0] ADDR_STATUS = 4'h0;
  localparam logic [3:0] ADDR_FRAME  = 4'h4;
  localparam logic [3:0] ADDR_COUNT  = 4'h8;
  localparam logic [3:0] ADDR_CTRL   = 4'hc;

  localparam int ST_FRAME_READY = 0;
  localparam int ST_SMP_EMPTY   = 1;
  localparam int ST_SMP_AEMPTY  = 2;
  localparam int ST_SMP_AFULL   = 3;
  localparam int ST_SMP_FULL    = 4;
  localparam int ST_MRK_EMPTY   = 5;
  localparam int ST_MRK_AEMPTY  = 6;
  localparam int ST_MRK_AFULL   = 7;
  localparam int ST_MRK_FULL    = 8;
  localparam int ST_SMP_OVF     = 9;
  localparam int ST_MRK_OVF     = 10;

  localparam int CTRL_CLR_SMP_OVF = 0;
  localparam int CTRL_CLR_MRK_OVF = 1;

  localparam int COUNT_SMP_LSB = 0;   // bits 8..0
  localparam int COUNT_MRK_LSB = 16;  // bits 24..16
  localparam int COUNT_FIELD_W = 9;

endpackage

`default_nettype wire

//--- src/fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
  parameter type payload_t      = logic [7:0],
  parameter int FIFO_DEPTH_BITS = pairer_pkg::FIFO_DEPTH_BITS
) ();

  logic                     pop;
  payload_t                 data;
  logic                     data_valid;
  logic                     empty;
  logic                     almostempty;
  logic                     almostfull;
  logic                     full;
  logic [FIFO_DEPTH_BITS:0] count;  // one wider than the pointers

  modport reader (
    output pop,
    input  data, data_valid,
    input  empty, almostempty, almostfull, full, count
  );

  modport fifo (
    input  pop,
    output data, data_valid,
    output empty, almostempty, almostfull, full, count
  );

  // status only, for the register block
  modport monitor (
    input empty, almostempty, almostfull, full, count
  );

endinterface

`default_nettype wire

//--- src/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t      = pairer_pkg::sample_t,
  parameter int FIFO_DEPTH_BITS = pairer_pkg::FIFO_DEPTH_BITS
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t din,
  fifo_if.fifo     rd,
  output logic     drop
);
  import pairer_pkg::*;

  typedef logic [FIFO_DEPTH_BITS-1:0] ptr_t;
  typedef logic [FIFO_DEPTH_BITS:0]   cnt_t;

  // almost-full sits the same distance below the top at any depth
  localparam int   AF_MARGIN = 2 ** pairer_pkg::FIFO_DEPTH_BITS - FIFO_ALMOSTFULL_LEVEL;
  localparam cnt_t DEPTH     = cnt_t'(2 ** FIFO_DEPTH_BITS);
  localparam cnt_t AF_LEVEL  = cnt_t'(2 ** FIFO_DEPTH_BITS - AF_MARGIN);
  localparam cnt_t AE_LEVEL  = cnt_t'(FIFO_ALMOSTEMPTY_LEVEL);

  payload_t mem [0:2 ** FIFO_DEPTH_BITS - 1];
  ptr_t     rp;
  ptr_t     wp;
  cnt_t     count;
  logic     empty;
  logic     almostempty;
  logic     almostfull;
  logic     full;
  logic     push_ok;
  logic     pop_ok;
  payload_t dout;
  logic     valid;

  assign push_ok = push && !full;
  assign pop_ok  = rd.pop && !empty;
  assign drop    = push && full;  // lost write

  always_ff @(posedge clk) begin
    if (rst) begin
      rp          <= '0;
      wp          <= '0;
      count       <= '0;
      empty       <= 1'b1;
      almostempty <= 1'b1;
      almostfull  <= 1'b0;
      full        <= 1'b0;
    end else begin
      case ({push_ok, pop_ok})
        2'b11: begin
          rp <= rp + 1'b1;  // count and flags hold
          wp <= wp + 1'b1;
        end
        2'b10: begin
          wp    <= wp + 1'b1;
          count <= count + 1'b1;
          empty <= 1'b0;
          if (count == AE_LEVEL - 1'b1) begin
            almostempty <= 1'b0;
          end
          if (count == AF_LEVEL - 1'b1) begin
            almostfull <= 1'b1;
          end
          if (count == DEPTH - 1'b1) begin
            full <= 1'b1;
          end
        end
        2'b01: begin
          rp    <= rp + 1'b1;
          count <= count - 1'b1;
          full  <= 1'b0;
          if (count == AF_LEVEL) begin
            almostfull <= 1'b0;
          end
          if (count == AE_LEVEL) begin
            almostempty <= 1'b1;
          end
          if (count == 1) begin
            empty <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wp] <= din;
    end
    if (pop_ok) begin
      dout <= mem[rp];  // registered read port
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= pop_ok;
    end
  end

  assign rd.data        = dout;
  assign rd.data_valid  = valid;
  assign rd.empty       = empty;
  assign rd.almostempty = almostempty;
  assign rd.almostfull  = almostfull;
  assign rd.full        = full;
  assign rd.count       = count;

  a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= DEPTH)
    else $error("fifo count above depth");

  a_empty_zero: assert property (@(posedge clk) disable iff (rst) empty |-> count == '0)
    else $error("fifo empty with entries held");

endmodule

`default_nettype wire

//--- src/frame_packer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_packer (
  input  logic               clk,
  input  logic               rst,
  fifo_if.reader             smp,
  fifo_if.reader             mrk,
  input  logic               frame_take,
  output pairer_pkg::frame_t frame,
  output logic               frame_ready
);
  import pairer_pkg::*;

  logic start;
  logic in_flight;
  logic pair_valid;

  // both sides must have an entry, and the holding slot must be free
  assign start = !smp.empty && !mrk.empty && !frame_ready && !in_flight && !frame_take;

  assign smp.pop = start;
  assign mrk.pop = start;

  assign pair_valid = smp.data_valid && mrk.data_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 1'b0;
    end else if (start) begin
      in_flight <= 1'b1;
    end else if (pair_valid) begin
      in_flight <= 1'b0;  // data is back
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_ready <= 1'b0;
    end else if (pair_valid) begin
      frame_ready <= 1'b1;
    end else if (frame_take) begin
      frame_ready <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pair_valid) begin
      frame.marker <= mrk.data;
      frame.sample <= smp.data;
    end
  end

  a_valid_paired: assert property (
    @(posedge clk) disable iff (rst) smp.data_valid == mrk.data_valid
  ) else $error("sample and marker returned in different cycles");

  // a pair popped while a frame is held would land on top of it
  a_no_return_held: assert property (
    @(posedge clk) disable iff (rst) frame_ready |-> !smp.data_valid && !mrk.data_valid
  ) else $error("pair returned while a frame is held");

  a_pop_returns: assert property (
    @(posedge clk) disable iff (rst) start |=> pair_valid ##1 frame_ready
  ) else $error("popped pair did not reach the frame register");

endmodule

`default_nettype wire

//--- src/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
  input  logic               clk,
  input  logic               rst,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [3:0]         paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  input  pairer_pkg::frame_t frame,
  input  logic               frame_ready,
  output logic               frame_take,
  fifo_if.monitor            smp,
  fifo_if.monitor            mrk,
  input  logic               sample_drop,
  input  logic               marker_drop
);
  import pairer_pkg::*;

  logic        access;
  logic        rd_acc;
  logic        wr_acc;
  logic        clr_smp;
  logic        clr_mrk;
  logic        smp_ovf;
  logic        mrk_ovf;
  logic [31:0] status_word;
  logic [31:0] count_word;

  assign access = psel && penable;
  assign rd_acc = access && !pwrite;
  assign wr_acc = access && pwrite;
  assign pready = 1'b1;  // zero wait states

  assign frame_take = rd_acc && (paddr == ADDR_FRAME) && frame_ready;

  assign clr_smp = wr_acc && (paddr == ADDR_CTRL) && pwdata[CTRL_CLR_SMP_OVF];
  assign clr_mrk = wr_acc && (paddr == ADDR_CTRL) && pwdata[CTRL_CLR_MRK_OVF];

  // a drop in the same cycle as a clear wins
  always_ff @(posedge clk) begin
    if (rst) begin
      smp_ovf <= 1'b0;
      mrk_ovf <= 1'b0;
    end else begin
      smp_ovf <= sample_drop || (smp_ovf && !clr_smp);
      mrk_ovf <= marker_drop || (mrk_ovf && !clr_mrk);
    end
  end

  always_comb begin
    status_word                 = '0;
    status_word[ST_FRAME_READY] = frame_ready;
    status_word[ST_SMP_EMPTY]   = smp.empty;
    status_word[ST_SMP_AEMPTY]  = smp.almostempty;
    status_word[ST_SMP_AFULL]   = smp.almostfull;
    status_word[ST_SMP_FULL]    = smp.full;
    status_word[ST_MRK_EMPTY]   = mrk.empty;
    status_word[ST_MRK_AEMPTY]  = mrk.almostempty;
    status_word[ST_MRK_AFULL]   = mrk.almostfull;
    status_word[ST_MRK_FULL]    = mrk.full;
    status_word[ST_SMP_OVF]     = smp_ovf;
    status_word[ST_MRK_OVF]     = mrk_ovf;
  end

  always_comb begin
    count_word = '0;
    count_word[COUNT_SMP_LSB +: COUNT_FIELD_W] = COUNT_FIELD_W'(smp.count);
    count_word[COUNT_MRK_LSB +: COUNT_FIELD_W] = COUNT_FIELD_W'(mrk.count);
  end

  // writes to read-only registers are ignored
  always_comb begin
    prdata  = '0;
    pslverr = 1'b0;
    if (access) begin
      case (paddr)
        ADDR_STATUS: begin
          if (!pwrite) begin
            prdata = status_word;
          end
        end
        ADDR_FRAME: begin
          if (!pwrite) begin
            if (frame_ready) begin
              prdata = {8'h00, frame};
            end else begin
              pslverr = 1'b1;  // nothing held
            end
          end
        end
        ADDR_COUNT: begin
          if (!pwrite) begin
            prdata = count_word;
          end
        end
        ADDR_CTRL: begin
          if (!pwrite) begin
            prdata = {30'd0, mrk_ovf, smp_ovf};  // sticky bits in clear positions
          end
        end
        default: begin
          pslverr = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/stream_pairer_top.sv
`timescale 1ns/1ps
`default_nettype none

module stream_pairer_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                sample_we,
  input  pairer_pkg::sample_t sample_din,
  input  logic                marker_we,
  input  pairer_pkg::marker_t marker_din,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [3:0]          paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr
);
  import pairer_pkg::*;

  frame_t frame;
  logic   frame_ready;
  logic   frame_take;
  logic   sample_drop;
  logic   marker_drop;

  fifo_if #(.payload_t(sample_t), .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) sample_if ();
  fifo_if #(.payload_t(marker_t), .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) marker_if ();

  sync_fifo #(
    .payload_t      (sample_t),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) i_sample_fifo (
    .clk (clk),
    .rst (rst),
    .push(sample_we),
    .din (sample_din),
    .rd  (sample_if),
    .drop(sample_drop)
  );

  sync_fifo #(
    .payload_t      (marker_t),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) i_marker_fifo (
    .clk (clk),
    .rst (rst),
    .push(marker_we),
    .din (marker_din),
    .rd  (marker_if),
    .drop(marker_drop)
  );

  frame_packer i_packer (
    .clk        (clk),
    .rst        (rst),
    .smp        (sample_if),
    .mrk        (marker_if),
    .frame_take (frame_take),
    .frame      (frame),
    .frame_ready(frame_ready)
  );

  apb_regs i_regs (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .frame      (frame),
    .frame_ready(frame_ready),
    .frame_take (frame_take),
    .smp        (sample_if),
    .mrk        (marker_if),
    .sample_drop(sample_drop),
    .marker_drop(marker_drop)
  );

endmodule

`default_nettype wire

//--- dv/tb_stream_pairer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stream_pairer;

  localparam int POLL_LIMIT = 200;
  localparam int DEPTH      = 2 ** pairer_pkg::FIFO_DEPTH_BITS;

  logic                clk;
  logic                rst;
  logic                sample_we;
  pairer_pkg::sample_t sample_din;
  logic                marker_we;
  pairer_pkg::marker_t marker_din;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [3:0]          paddr;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;

  pairer_pkg::sample_t smp_q[$];  // accepted, not yet read out
  pairer_pkg::marker_t mrk_q[$];
  int                  cycle = 0;

  stream_pairer_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .sample_we (sample_we),
    .sample_din(sample_din),
    .marker_we (marker_we),
    .marker_din(marker_din),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("ERR t=%0t %s got=0x%08h exp=0x%08h", $time, name, got, exp));
    end
  endtask

  // one frame sits in the packer once both streams have an entry
  function automatic int pair_held();
    return (smp_q.size() > 0 && mrk_q.size() > 0) ? 1 : 0;
  endfunction

  task automatic push_streams(input logic s_we, input logic [15:0] s,
                              input logic m_we, input logic [7:0] m);
    int s_level;
    int m_level;
    s_level = smp_q.size() - pair_held();
    m_level = mrk_q.size() - pair_held();
    @(posedge clk);
    #1;
    sample_we  = s_we;
    sample_din = s;
    marker_we  = m_we;
    marker_din = m;
    if (s_we && s_level < DEPTH) begin
      smp_q.push_back(s);
    end
    if (m_we && m_level < DEPTH) begin
      mrk_q.push_back(m);
    end
    @(posedge clk);
    #1;
    sample_we = 1'b0;
    marker_we = 1'b0;
  endtask

  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] data, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    data = prdata;  // mid-cycle, settled
    err  = pslverr;
    expect_equal("pready", 32'(pready), 32'd1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_frame();
    logic [31:0]         data;
    logic                err;
    int                  start;
    pairer_pkg::sample_t s;
    pairer_pkg::marker_t m;
    if (pair_held() == 0) begin
      fail_stop("input file asks for a frame while the model holds no pair");
    end
    start = cycle;
    data  = '0;
    while (data[pairer_pkg::ST_FRAME_READY] == 1'b0) begin
      if (cycle - start > POLL_LIMIT) begin
        fail_stop("timeout: frame_ready did not rise within 200 cycles");
      end
      apb_access(1'b0, pairer_pkg::ADDR_STATUS, 32'd0, data, err);
      expect_equal("status pslverr", 32'(err), 32'd0);
    end
    apb_access(1'b0, pairer_pkg::ADDR_FRAME, 32'd0, data, err);
    m = mrk_q.pop_front();
    s = smp_q.pop_front();
    expect_equal("frame", data, {8'h00, m, s});
    expect_equal("frame pslverr", 32'(err), 32'd0);
  endtask

  task automatic check_count();
    logic [31:0] data;
    logic        err;
    logic [31:0] want;
    want = 32'((mrk_q.size() - pair_held()) << pairer_pkg::COUNT_MRK_LSB)
         | 32'((smp_q.size() - pair_held()) << pairer_pkg::COUNT_SMP_LSB);
    apb_access(1'b0, pairer_pkg::ADDR_COUNT, 32'd0, data, err);
    expect_equal("count", data, want);
    expect_equal("count pslverr", 32'(err), 32'd0);
  endtask

  task automatic read_hex(input int fd, output logic [31:0] v);
    int code;
    code = $fscanf(fd, "%h", v);
    if (code != 1) begin
      fail_stop("input file ends in the middle of a command");
    end
  endtask

  task automatic skip_line(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  initial begin
    int          fd;
    int          code;
    logic [7:0]  cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] data;
    logic        err;
    logic        done;
    clk        = 1'b0;
    rst        = 1'b1;
    sample_we  = 1'b0;
    sample_din = '0;
    marker_we  = 1'b0;
    marker_din = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    fd = $fopen("dv/stream_input.txt", "r");
    if (fd == 0) begin
      fail_stop("could not open dv/stream_input.txt");
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        case (cmd)
          "#": skip_line(fd);
          "S": begin
            read_hex(fd, a);
            push_streams(1'b1, a[15:0], 1'b0, 8'h00);
          end
          "M": begin
            read_hex(fd, a);
            push_streams(1'b0, 16'h0000, 1'b1, a[7:0]);
          end
          "B": begin
            read_hex(fd, a);
            read_hex(fd, b);
            push_streams(1'b1, a[15:0], 1'b1, b[7:0]);
          end
          "R": read_frame();
          "E": begin
            apb_access(1'b0, pairer_pkg::ADDR_FRAME, 32'd0, data, err);
            expect_equal("empty frame pslverr", 32'(err), 32'd1);
            expect_equal("empty frame data", data, 32'd0);
          end
          "T": begin
            read_hex(fd, a);
            read_hex(fd, b);
            apb_access(1'b0, pairer_pkg::ADDR_STATUS, 32'd0, data, err);
            expect_equal("status", data & a, b & a);
            expect_equal("status pslverr", 32'(err), 32'd0);
          end
          "C": check_count();
          "X": begin
            apb_access(1'b0, 4'h2, 32'd0, data, err);  // hole in the map
            expect_equal("bad addr pslverr", 32'(err), 32'd1);
            expect_equal("bad addr data", data, 32'd0);
          end
          "W": begin
            read_hex(fd, a);
            apb_access(1'b1, pairer_pkg::ADDR_CTRL, a, data, err);
            expect_equal("ctrl pslverr", 32'(err), 32'd0);
          end
          "N": begin
            read_hex(fd, a);
            repeat (a) @(posedge clk);
          end
          default: fail_stop($sformatf("unknown command %c in input file", cmd));
        endcase
      end
    end
    $fclose(fd);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
src/pairer_pkg.sv
src/fifo_if.sv
src/sync_fifo.sv
src/frame_packer.sv
src/apb_regs.sv
src/stream_pairer_top.sv
dv/tb_stream_pairer.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tb_stream_pairer
RTL_TOP    := stream_pairer_top
FILELIST   := sources.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := SIMULATION FAILED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim: failure reported in $(LOG)"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "sim: simulator exited with status $$status"; exit 1; fi; \
	echo "sim: no failure reported in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/stream_input.txt
# command then hex arguments, several commands may share a line
# S smp | M mrk | B smp mrk | R | E | T mask value | C | X | W ctrl | N cycles
N 2
T 7ff 066
E
X
C
S 1001
N 2
T 01e 004
S 1002
N 2
T 01e 000
S 1003 S 1004 S 1005 S 1006 S 1007 S 1008 S 1009 S 100a S 100b
N 2
T 01e 000
S 100c
N 2
T 01e 008
S 100d S 100e S 100f
N 2
T 01e 008
S 1010
N 2
T 01e 018
C
# two pushes into a full sample fifo
S dead S beef
N 2
T 600 200
T 01e 018
W 1
T 600 000
M a1 M a2 M a3
N 8
C
R R
N 4
C
R
N 4
E
T 001 000
B 2001 b1 B 2002 b2 B 2003 b3
N 6
C
R R
N 4
C
M c1 M c2 S 3001
N 6
C
R R R
N 4
C
T 7ff 068
M d1 M d2 M d3 M d4 M d5 M d6 M d7 M d8 M d9
R R R R R R R R R
N 4
C
T 7ff 060
E
